// File: dcache_top.f
verilog/dcache_pkg.sv
verilog/mem_pkg.sv
verilog/burst_if.sv
verilog/beat_counter.sv
verilog/dword_ram.sv
verilog/read_path.sv
verilog/write_path.sv
verilog/burst_engine.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/dcache_assertions.sv
verification/dcache_tb.sv

// File: verification/dcache_assertions.sv
// Protocol checks bound into the access controller
// Checks are off while rst_n is low
`timescale 1ns/1ps
`default_nettype none

module dcache_assertions (
    input logic                    clk,
    input logic                    rst_n,
    input dcache_pkg::ctrl_state_t state,
    input logic                    do_burst,
    input logic                    done,
    input logic                    write_done,
    input logic                    can_accept
);

    // Number of failed assertions
    int fail_count = 0;

    // Burst start is a single-cycle pulse
    a_do_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        do_burst |=> !do_burst)
        else begin
            fail_count++;
            $error("burst do high for more than one cycle");
        end

    // Posted write ack exactly in the first WRITE_THROUGH cycle
    a_wr_ack: assert property (@(posedge clk) disable iff (!rst_n)
        write_done == (state == dcache_pkg::WRITE_THROUGH &&
                       $past(state) == dcache_pkg::IDLE))
        else begin
            fail_count++;
            $error("write_done does not follow write acceptance by one cycle");
        end

    // Busy from the start pulse until the burst reports done
    a_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (do_burst || (!can_accept && !done)) |=> !can_accept)
        else begin
            fail_count++;
            $error("can_accept high while the controller is busy");
        end

endmodule

`default_nettype wire

// File: verification/dcache_tb.sv
// Table-driven testbench for the data-side front end, checked against a byte model
// Bytes 0..127 are prefilled so that every read sees written memory
`timescale 1ns/1ps
`default_nettype none

module dcache_tb;

    localparam int TIMEOUT    = 40;
    localparam bit OP_RD      = 1'b0;
    localparam bit OP_WR      = 1'b1;
    localparam bit SRC_MODEL  = 1'b0;
    localparam bit SRC_LIT    = 1'b1;

    // Operation, address, byte length, write data or literal, expected-data source
    typedef struct packed {
        logic        op;
        logic [31:0] addr;
        logic [3:0]  len;
        logic [31:0] data;
        logic        src;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        read_do;
    logic [dcache_pkg::RD_LEN_W-1:0] read_length;
    logic [31:0] read_address;
    logic        read_done;
    logic [63:0] read_data;
    logic        write_do;
    logic [dcache_pkg::WR_LEN_W-1:0] write_length;
    logic [31:0] write_address;
    logic [31:0] write_data;
    logic        write_done;
    logic        can_accept;

    // Byte image of the 1 KiB memory, wraps like the DUT
    logic [7:0]  model [1024];
    row_t        rows [$];
    int          errors;
    int          checks;
    integer      seed;

    dcache_top uut (
        .clk(clk), .rst_n(rst_n),
        .read_do(read_do), .read_length(read_length), .read_address(read_address),
        .read_done(read_done), .read_data(read_data),
        .write_do(write_do), .write_length(write_length), .write_address(write_address),
        .write_data(write_data), .write_done(write_done), .can_accept(can_accept)
    );

    bind dcache_ctrl dcache_assertions u_assert (
        .clk(clk), .rst_n(rst_n), .state(state), .do_burst(burst.do_burst),
        .done(burst.done), .write_done(write_done), .can_accept(can_accept)
    );

    always #5 clk = ~clk;

    // ------------------------------------------------------------
    // Model and helpers
    // ------------------------------------------------------------
    function automatic void add_row(input logic op, input logic [31:0] addr,
                                    input logic [3:0] len, input logic [31:0] data,
                                    input logic src);
        row_t r;
        r = '{op: op, addr: addr, len: len, data: data, src: src};
        rows.push_back(r);
    endfunction

    // Least significant byte lands at the lowest address
    function automatic void mirror_write(input logic [31:0] addr, input int len,
                                         input logic [31:0] data);
        for (int i = 0; i < len; i++) begin
            model[10'(addr + 32'(i))] = data[8*i +: 8];
        end
    endfunction

    function automatic void compare_read(input logic [31:0] addr, input int len,
                                         input logic src, input logic [31:0] lit);
        logic [63:0] expected;
        logic [63:0] mask;
        expected = '0;
        mask     = '0;
        for (int i = 0; i < len; i++) begin
            expected[8*i +: 8] = model[10'(addr + 32'(i))];
            mask[8*i +: 8]     = 8'hff;
        end
        if (src == SRC_LIT) begin
            expected = {32'd0, lit};
        end
        checks++;
        if ((read_data & mask) !== (expected & mask)) begin
            errors++;
            $display("[FAIL] %0t: read %h len %0d returned %h, expected %h",
                     $time, addr, len, read_data & mask, expected & mask);
        end
    endfunction

    task automatic abort_on_timeout(input string what);
        $display("Timeout at %0t: no %s within %0d cycles", $time, what, TIMEOUT);
        $display("Checks: %0d, errors: %0d", checks, errors + 1);
        $display("Test failed");
        $finish;
    endtask

    task automatic wait_idle();
        int waited;
        waited = 0;
        while (!can_accept) begin
            if (waited == TIMEOUT) abort_on_timeout("can_accept");
            @(posedge clk);
            #1;
            waited++;
        end
    endtask

    // Both requests together exercise write priority
    task automatic run_access(input bit do_wr, input bit do_rd, input logic [31:0] addr,
                              input int wlen, input logic [31:0] data, input int rlen,
                              input logic src);
        int waited;
        bit wr_seen;
        bit gap_seen;
        wait_idle();
        write_address = addr;
        write_length  = 3'(wlen);
        write_data    = data;
        read_address  = addr;
        read_length   = 4'(rlen);
        write_do      = do_wr;
        read_do       = do_rd;
        waited   = 0;
        wr_seen  = 0;
        gap_seen = 0;
        while (do_rd ? !read_done : !wr_seen) begin
            if (waited == TIMEOUT) abort_on_timeout(do_rd ? "read_done" : "write_done");
            @(posedge clk);
            #1;
            waited++;
            // Busy from acceptance until the matching done
            // A read held behind a write is taken one cycle after IDLE
            if (can_accept) begin
                if (do_wr && do_rd && wr_seen && !gap_seen) begin
                    gap_seen = 1;
                end else begin
                    errors++;
                    $display("[FAIL] %0t: can_accept high during access at %h",
                             $time, addr);
                end
            end
            if (write_done && do_wr) begin
                wr_seen  = 1;
                write_do = 1'b0;
                mirror_write(addr, wlen, data);
                checks++;
                if (waited != 1) begin
                    errors++;
                    $display("[FAIL] %0t: write_done %0d cycles after request", $time, waited);
                end
            end
        end
        read_do = 1'b0;
        if (do_wr && !wr_seen) begin
            errors++;
            $display("[FAIL] %0t: read_done came before write_done", $time);
        end
        if (do_rd) compare_read(addr, rlen, src, data);
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        logic [31:0] addr;
        row_t        row;
        clk = 0;
        rst_n = 0;
        read_do = 0;
        read_length = '0;
        read_address = '0;
        write_do = 0;
        write_length = '0;
        write_address = '0;
        write_data = '0;
        errors = 0;
        checks = 0;
        seed = 72;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1;

        checks++;
        if (read_done !== 1'b0 || write_done !== 1'b0 || can_accept !== 1'b1) begin
            errors++;
            $display("[FAIL] %0t: outputs after reset %b%b%b, expected 001",
                     $time, read_done, write_done, can_accept);
        end

        // Fill pattern from the byte address
        for (int a = 0; a < 128; a += 4) begin
            run_access(1, 0, a, 4, {8'(a+3), 8'(a+2), 8'(a+1), 8'(a)} ^ 32'h5a5a_5a5a, 0,
                       SRC_MODEL);
        end

        add_row(OP_WR, 32'h40, 4, 32'h1234_5678, SRC_MODEL);
        add_row(OP_RD, 32'h40, 4, 32'h1234_5678, SRC_LIT);
        add_row(OP_WR, 32'h47, 2, 32'h0000_beef, SRC_MODEL);
        add_row(OP_RD, 32'h46, 4, 32'd0, SRC_MODEL);
        // Sweep of every write and read length at every offset
        for (int off = 0; off < 4; off++) begin
            for (int len = 1; len <= 4; len++) begin
                add_row(OP_WR, 32'h50 + 32'(off), 4'(len), 32'h9e37_79b9 * (4*off + len),
                        SRC_MODEL);
            end
            for (int len = 1; len <= 8; len++) begin
                add_row(OP_RD, 32'h50 + 32'(off), 4'(len), 32'd0, SRC_MODEL);
            end
        end
        foreach (rows[i]) begin
            row = rows[i];
            run_access(row.op == OP_WR, row.op == OP_RD, row.addr, row.len, row.data,
                       row.len, row.src);
        end

        // Simultaneous requests
        run_access(1, 1, 32'h45, 3, 32'h00c0_ffee, 6, SRC_MODEL);

        // Random mix over the low 64 bytes
        for (int n = 0; n < 200; n++) begin
            addr = $unsigned($random(seed)) % 64;
            if ($random(seed) & 1) begin
                run_access(1, 0, addr, 1 + $unsigned($random(seed)) % 4, $random(seed), 0,
                           SRC_MODEL);
            end else begin
                run_access(0, 1, addr, 0, 32'd0, 1 + $unsigned($random(seed)) % 8,
                           SRC_MODEL);
            end
        end

        wait_idle();
        errors += uut.u_ctrl.u_assert.fail_count;
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/beat_counter.sv
// Beat counter for one burst; load and step never come in the same cycle
`timescale 1ns/1ps
`default_nettype none

module beat_counter (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               load,
    input  logic                               step,
    input  logic [dcache_pkg::DWORD_LEN_W-1:0] count,
    output logic [dcache_pkg::DWORD_LEN_W-1:0] index,
    output logic                               last
);

    // Beats still to go, current beat included
    logic [dcache_pkg::DWORD_LEN_W-1:0] remaining;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            remaining <= '0;
            index     <= '0;
        end else if (load) begin
            remaining <= count;
            index     <= '0;
        end else if (step) begin
            remaining <= remaining - 1'b1;
            index     <= index + 1'b1;
        end
    end

    assign last = (remaining == 1);

endmodule

`default_nettype wire

// File: verilog/burst_engine.sv
// Runs one burst against the dword memory, one beat per cycle
// Read done lands N+2 cycles after start, write done N+1; rdata holds until the next read
`timescale 1ns/1ps
`default_nettype none

module burst_engine (
    input  logic                               clk,
    input  logic                               rst_n,
    burst_if.engine                            burst,
    // Beat counter
    output logic                               load,
    output logic                               step,
    output logic [dcache_pkg::DWORD_LEN_W-1:0] count,
    input  logic [dcache_pkg::DWORD_LEN_W-1:0] index,
    input  logic                               last,
    // Memory
    output logic [mem_pkg::MEM_AW-1:0]         addr,
    output logic [3:0]                         be,
    output logic [31:0]                        mem_wdata,
    output logic                               we,
    input  logic [31:0]                        mem_rdata
);

    localparam int PAD_W = mem_pkg::MEM_AW - dcache_pkg::DWORD_LEN_W;

    logic                               busy;
    logic                               is_write;
    logic [mem_pkg::MEM_AW-1:0]         base_q;
    logic [3:0]                         be0_q;
    logic [3:0]                         be1_q;
    logic [55:0]                        wdata_q;
    // Read beat in flight through the registered memory
    logic                               rd_pending;
    logic                               rd_last;
    logic [dcache_pkg::DWORD_LEN_W-1:0] rd_slot;

    assign load  = burst.do_burst;
    assign count = burst.dword_length;
    assign step  = busy;

    // ------------------------------------------------------------
    // Memory beat
    // ------------------------------------------------------------

    // Aligned start plus beat index, wraps at memory end
    assign addr      = base_q + {{PAD_W{1'b0}}, index};
    assign we        = busy && is_write;
    // First dword takes the low lanes, second the upper 24 bits
    assign be        = (index == '0) ? be0_q : be1_q;
    assign mem_wdata = (index == '0) ? wdata_q[31:0] : {8'd0, wdata_q[55:32]};

    // ------------------------------------------------------------
    // Control
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy       <= 1'b0;
            rd_pending <= 1'b0;
            burst.done <= 1'b0;
        end else begin
            if (burst.do_burst) begin
                busy <= 1'b1;
            end else if (busy && last) begin
                busy <= 1'b0;
            end
            rd_pending <= busy && !is_write;
            // Write ends with its last beat, read once the last data is back
            burst.done <= (busy && last && is_write) || (rd_pending && rd_last);
        end
    end

    // ------------------------------------------------------------
    // Burst fields and read gather
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (burst.do_burst) begin
            is_write <= burst.write;
            base_q   <= burst.address[mem_pkg::MEM_AW+1:2];
            be0_q    <= burst.byteenable_0;
            be1_q    <= burst.byteenable_1;
            wdata_q  <= burst.wdata;
        end
        rd_slot <= index;
        rd_last <= last;

        // Unfetched slots read as zero
        if (burst.do_burst && !burst.write) begin
            burst.rdata <= '0;
        end
        if (rd_pending) begin
            burst.rdata.dwords[rd_slot] <= mem_rdata;
        end
    end

endmodule

`default_nettype wire

// File: verilog/burst_if.sv
// One dword burst between access controller and burst engine
// do_burst and done are single-cycle pulses; fields are sampled on do_burst
`timescale 1ns/1ps
`default_nettype none

interface burst_if;

    // Start pulse and completion pulse
    logic                               do_burst;
    logic                               done;

    // Burst request fields
    logic [31:0]                        address;
    logic [dcache_pkg::DWORD_LEN_W-1:0] dword_length;
    logic [3:0]                         byteenable_0;
    logic [3:0]                         byteenable_1;
    logic [55:0]                        wdata;
    logic                               write;

    // Read result, valid from done onwards
    dcache_pkg::rd_burst_u              rdata;

    modport ctrl (
        output do_burst, address, dword_length, byteenable_0, byteenable_1, wdata, write,
        input  done, rdata
    );

    modport engine (
        input  do_burst, address, dword_length, byteenable_0, byteenable_1, wdata, write,
        output done, rdata
    );

endinterface

`default_nettype wire

// File: verilog/dcache_ctrl.sv
// Access FSM; writes win over reads and are acknowledged before the burst ends
// Requesters hold their do level until done; nothing is taken outside IDLE
`timescale 1ns/1ps
`default_nettype none

module dcache_ctrl (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       read_do,
    input  logic       write_do,
    output logic       read_done,
    output logic       write_done,
    output logic       can_accept,
    output logic [1:0] rd_offset,
    burst_if.ctrl      burst
);

    dcache_pkg::ctrl_state_t state;
    logic [1:0]              offset_q;

    // ------------------------------------------------------------
    // Burst request
    // ------------------------------------------------------------

    // Start only in the cycle we leave IDLE
    assign burst.do_burst = (state == dcache_pkg::IDLE) && (write_do || read_do);
    // Write priority, same as the state choice below
    assign burst.write    = write_do;

    assign can_accept = (state == dcache_pkg::IDLE);
    // Read completes together with the engine pulse
    assign read_done  = (state == dcache_pkg::READ_BURST) && burst.done;
    assign rd_offset  = offset_q;

    // ------------------------------------------------------------
    // State machine
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= dcache_pkg::IDLE;
            write_done <= 1'b0;
        end else begin
            write_done <= 1'b0;
            case (state)
                dcache_pkg::IDLE: begin
                    if (write_do) begin
                        // Posted write, ack right away
                        state      <= dcache_pkg::WRITE_THROUGH;
                        write_done <= 1'b1;
                    end else if (read_do) begin
                        state <= dcache_pkg::READ_BURST;
                    end
                end
                dcache_pkg::READ_BURST: begin
                    if (burst.done) begin
                        state <= dcache_pkg::IDLE;
                    end
                end
                dcache_pkg::WRITE_THROUGH: begin
                    if (burst.done) begin
                        state <= dcache_pkg::IDLE;
                    end
                end
                default: state <= dcache_pkg::IDLE;
            endcase
        end
    end

    // Byte offset for aligning read data, kept for the whole burst
    always_ff @(posedge clk) begin
        if (state == dcache_pkg::IDLE) begin
            offset_q <= burst.address[1:0];
        end
    end

endmodule

`default_nettype wire

// File: verilog/dcache_pkg.sv
// Access-side definitions shared by the controller, both paths and the burst engine
// Reads span at most three dwords and writes at most two
`default_nettype none

package dcache_pkg;

    // Byte length widths, reads 1..8 and writes 1..4
    localparam int RD_LEN_W    = 4;
    localparam int WR_LEN_W    = 3;
    // Burst length in dwords, 1..3
    localparam int DWORD_LEN_W = 2;

    // Access state machine
    typedef enum logic [1:0] {
        IDLE          = 2'd0,
        READ_BURST    = 2'd1,
        WRITE_THROUGH = 2'd2
    } ctrl_state_t;

    // Gathered read burst
    // Engine fills dword slots, read path picks bytes by offset
    typedef union packed {
        logic [2:0][31:0] dwords;
        logic [11:0][7:0] bytes;
    } rd_burst_u;

endpackage

`default_nettype wire

// File: verilog/dcache_top.sv
// Data-side memory front end: byte reads of 1..8 and writes of 1..4 at any address
// Pass-through, no tags; address bits above the memory range are ignored
`timescale 1ns/1ps
`default_nettype none

module dcache_top (
    input  logic                            clk,
    input  logic                            rst_n,
    // Read port
    input  logic                            read_do,
    input  logic [dcache_pkg::RD_LEN_W-1:0] read_length,
    input  logic [31:0]                     read_address,
    output logic                            read_done,
    output logic [63:0]                     read_data,
    // Write port
    input  logic                            write_do,
    input  logic [dcache_pkg::WR_LEN_W-1:0] write_length,
    input  logic [31:0]                     write_address,
    input  logic [31:0]                     write_data,
    output logic                            write_done,
    output logic                            can_accept
);

    burst_if bus ();

    logic [1:0]                         rd_offset;
    logic [dcache_pkg::DWORD_LEN_W-1:0] rd_dwords;
    logic [dcache_pkg::DWORD_LEN_W-1:0] wr_dwords;
    // Engine to beat counter
    logic                               cnt_load;
    logic                               cnt_step;
    logic [dcache_pkg::DWORD_LEN_W-1:0] cnt_count;
    logic [dcache_pkg::DWORD_LEN_W-1:0] cnt_index;
    logic                               cnt_last;
    // Engine to memory
    logic [mem_pkg::MEM_AW-1:0]         mem_addr;
    logic [3:0]                         mem_be;
    logic [31:0]                        mem_wdata;
    logic                               mem_we;
    logic [31:0]                        mem_rdata;

    // Burst fields from the side that wins, write first
    assign bus.address      = write_do ? write_address : read_address;
    assign bus.dword_length = write_do ? wr_dwords : rd_dwords;

    dcache_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .read_do    (read_do),
        .write_do   (write_do),
        .read_done  (read_done),
        .write_done (write_done),
        .can_accept (can_accept),
        .rd_offset  (rd_offset),
        .burst      (bus.ctrl)
    );

    read_path u_read_path (
        .read_length  (read_length),
        .read_address (read_address),
        .rd_offset    (rd_offset),
        .burst_rdata  (bus.rdata),
        .dword_length (rd_dwords),
        .read_data    (read_data)
    );

    write_path u_write_path (
        .write_length  (write_length),
        .write_address (write_address),
        .write_data    (write_data),
        .dword_length  (wr_dwords),
        .byteenable_0  (bus.byteenable_0),
        .byteenable_1  (bus.byteenable_1),
        .burst_wdata   (bus.wdata)
    );

    burst_engine u_engine (
        .clk       (clk),
        .rst_n     (rst_n),
        .burst     (bus.engine),
        .load      (cnt_load),
        .step      (cnt_step),
        .count     (cnt_count),
        .index     (cnt_index),
        .last      (cnt_last),
        .addr      (mem_addr),
        .be        (mem_be),
        .mem_wdata (mem_wdata),
        .we        (mem_we),
        .mem_rdata (mem_rdata)
    );

    beat_counter u_beat_counter (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (cnt_load),
        .step  (cnt_step),
        .count (cnt_count),
        .index (cnt_index),
        .last  (cnt_last)
    );

    dword_ram u_ram (
        .clk   (clk),
        .addr  (mem_addr),
        .be    (mem_be),
        .wdata (mem_wdata),
        .we    (mem_we),
        .rdata (mem_rdata)
    );

endmodule

`default_nettype wire

// File: verilog/dword_ram.sv
// Dword memory, byte writes, registered read returning old data on collision
// No reset, contents undefined until written
`timescale 1ns/1ps
`default_nettype none

module dword_ram (
    input  logic                       clk,
    input  logic [mem_pkg::MEM_AW-1:0] addr,
    input  logic [3:0]                 be,
    input  logic [31:0]                wdata,
    input  logic                       we,
    output logic [31:0]                rdata
);

    logic [31:0] mem [mem_pkg::MEM_DEPTH];

    always_ff @(posedge clk) begin
        // Per-byte write
        if (we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[addr][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
        // One-cycle read latency
        rdata <= mem[addr];
    end

endmodule

`default_nettype wire

// File: verilog/mem_pkg.sv
// On-chip dword memory geometry; higher address bits wrap
`default_nettype none

package mem_pkg;

    // Dword address width and depth
    localparam int MEM_AW    = 8;
    localparam int MEM_DEPTH = 1 << MEM_AW;

endpackage

`default_nettype wire

// File: verilog/read_path.sv
// Read span decode and alignment of the gathered burst
// read_length is 1..8; rd_offset must be the offset latched at acceptance
`timescale 1ns/1ps
`default_nettype none

module read_path (
    input  logic [dcache_pkg::RD_LEN_W-1:0]    read_length,
    input  logic [31:0]                        read_address,
    input  logic [1:0]                         rd_offset,
    input  dcache_pkg::rd_burst_u              burst_rdata,
    output logic [dcache_pkg::DWORD_LEN_W-1:0] dword_length,
    output logic [63:0]                        read_data
);

    logic [4:0] span_end;
    logic [3:0] byte_idx;

    // ------------------------------------------------------------
    // Dword span
    // ------------------------------------------------------------

    // Offset plus length rounded up to whole dwords
    // 1 dword up to 4 bytes in one word, 3 dwords for long unaligned reads
    assign span_end     = 5'(read_address[1:0]) + 5'(read_length) + 5'd3;
    assign dword_length = span_end[3:2];

    // ------------------------------------------------------------
    // Alignment
    // ------------------------------------------------------------

    // Eight bytes starting at the offset, lowest byte first
    always_comb begin
        byte_idx  = 4'd0;
        read_data = '0;
        for (int i = 0; i < 8; i++) begin
            byte_idx               = 4'(rd_offset) + 4'(i);
            read_data[8*i +: 8]    = burst_rdata.bytes[byte_idx];
        end
    end

endmodule

`default_nettype wire

// File: verilog/write_path.sv
// Write span decode, byte enables and lane shift
// write_length is 1..4, so a write touches at most two dwords
`timescale 1ns/1ps
`default_nettype none

module write_path (
    input  logic [dcache_pkg::WR_LEN_W-1:0]    write_length,
    input  logic [31:0]                        write_address,
    input  logic [31:0]                        write_data,
    output logic [dcache_pkg::DWORD_LEN_W-1:0] dword_length,
    output logic [3:0]                         byteenable_0,
    output logic [3:0]                         byteenable_1,
    output logic [55:0]                        burst_wdata
);

    logic [1:0] offset;
    logic [3:0] span_end;
    logic [7:0] len_mask;
    logic [7:0] lane_mask;

    assign offset = write_address[1:0];

    // Two dwords only when the bytes cross a dword boundary
    assign span_end     = 4'(offset) + 4'(write_length) + 4'd3;
    assign dword_length = span_end[3:2];

    // ------------------------------------------------------------
    // Byte enables
    // ------------------------------------------------------------

    // Bytes offset .. offset+len-1 over both dwords
    assign len_mask     = (8'd1 << write_length) - 8'd1;
    assign lane_mask    = len_mask << offset;
    assign byteenable_0 = lane_mask[3:0];
    assign byteenable_1 = lane_mask[7:4];

    // ------------------------------------------------------------
    // Lane shift
    // ------------------------------------------------------------

    // Data moves up by the byte offset
    // Low 32 bits go to the first dword, upper 24 to the second
    assign burst_wdata = {24'd0, write_data} << (8 * offset);

endmodule

`default_nettype wire
